//--- design/fe_settings.svh
/* Front end settings
   Datapath width, reset fetch address and branch table sizing */

`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// Data and address width
`define FE_XLEN 32

// First fetch address after reset
`define FE_PC_INIT 'h200

// Number of 2-bit counters in the branch table
`define FE_BHT_ENTRIES 64

// Global history length
`define FE_HIST_BITS 2

`endif

//--- design/fe_pkg.sv
/* Front end package
   Pipeline structs, RV32 opcode constants and field decoders */

`include "fe_settings.svh"

package fe_pkg;

  ////////////////////
  // Types

  typedef logic [31:0] instr_t;

  // Pipeline slot, bubble marks it empty
  typedef struct packed {
    instr_t instr;
    logic   bubble;
  } insn_t;

  typedef struct packed {
    logic fetch_fault;
    logic illegal;
    logic any;
  } exc_t;

  typedef logic [4:0] rsd_t;

  // Branch resolution from the branch unit
  typedef struct packed {
    logic                     valid;
    logic [`FE_XLEN-1:0]      pc;
    logic                     taken;
    logic [`FE_HIST_BITS-1:0] history;
  } bp_update_t;

  // Controller to fetch
  typedef struct packed {
    logic                hold;
    logic                load;
    logic [`FE_XLEN-1:0] nxt_pc;
    logic                kill;
  } fetch_ctl_t;

  ////////////////////
  // Constants

  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // CSR access funct3 codes
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // addi x0,x0,0
  localparam instr_t INSTR_NOP = 32'h0000_0013;

  ////////////////////
  // Field decoders

  function automatic logic [6:0] decode_opcode(input instr_t i);
    return i[6:0];
  endfunction

  function automatic rsd_t decode_rs1(input instr_t i);
    return i[19:15];
  endfunction

  function automatic rsd_t decode_rs2(input instr_t i);
    return i[24:20];
  endfunction

  function automatic logic [2:0] decode_funct3(input instr_t i);
    return i[14:12];
  endfunction

  function automatic logic [11:0] decode_csr(input instr_t i);
    return i[31:20];
  endfunction

  // JAL offset, sign extended
  function automatic logic [`FE_XLEN-1:0] decode_imm_uj(input instr_t i);
    return {{(`FE_XLEN-20){i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
  endfunction

  // Branch offset, sign extended
  function automatic logic [`FE_XLEN-1:0] decode_imm_sb(input instr_t i);
    return {{(`FE_XLEN-12){i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
  endfunction

endpackage

//--- design/fe_ctrl.sv
/* Front end controller
   Stall merge, next fetch PC priority and wrong-path kill */

`timescale 1ns/1ns
`include "fe_settings.svh"

module fe_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   id_stall_i,
  input  logic                   local_stall_i,
  input  logic                   st_flush_i,
  input  logic [`FE_XLEN-1:0]    st_nxt_pc_i,
  input  logic                   bu_flush_i,
  input  logic [`FE_XLEN-1:0]    bu_nxt_pc_i,
  input  logic                   redirect_i,
  input  logic [`FE_XLEN-1:0]    redirect_pc_i,
  output fe_pkg::fetch_ctl_t     fetch_ctl_o,
  output logic                   fe_stall_o,
  output logic                   pd_flush_o
);

  // Set for one cycle after any PC load
  logic kill_q;

  // Decode and pre-decode both wait
  assign fe_stall_o = id_stall_i | local_stall_i;

  assign pd_flush_o = st_flush_i | bu_flush_i;

  ////////////////////
  // Next PC select

  always_comb begin
    fetch_ctl_o.hold = fe_stall_o;
    fetch_ctl_o.kill = kill_q;
    fetch_ctl_o.load = 1'b1;
    if (st_flush_i) begin
      fetch_ctl_o.nxt_pc = st_nxt_pc_i;
    end else if (bu_flush_i) begin
      fetch_ctl_o.nxt_pc = bu_nxt_pc_i;
    end else if (redirect_i) begin
      fetch_ctl_o.nxt_pc = redirect_pc_i;
    end else begin
      // Sequential, fetch steps its own PC
      fetch_ctl_o.load   = 1'b0;
      fetch_ctl_o.nxt_pc = redirect_pc_i;
    end
  end

  ////////////////////
  // Wrong-path kill

  // Word requested in the load cycle is stale
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) kill_q <= 1'b0;
    else         kill_q <= fetch_ctl_o.load;
  end

endmodule

//--- design/fe_fetch.sv
/* Instruction fetch
   PC register, memory request and pairing of returned words with their PC */

`timescale 1ns/1ns
`include "fe_settings.svh"

module fe_fetch (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  fe_pkg::fetch_ctl_t   fetch_ctl_i,
  input  fe_pkg::instr_t       imem_instr_i,
  input  logic                 imem_err_i,
  output logic [`FE_XLEN-1:0]  imem_addr_o,
  output logic                 imem_req_o,
  output logic [`FE_XLEN-1:0]  fetch_pc_o,
  output logic [`FE_XLEN-1:0]  if_pc_o,
  output fe_pkg::insn_t        if_insn_o,
  output fe_pkg::exc_t         if_exc_o
);

  // Word aligned, no compressed instructions
  localparam logic [`FE_XLEN-1:0] ADR_MASK = {`FE_XLEN{1'b1}} << 2;

  logic [`FE_XLEN-1:0] pc_q;
  logic [`FE_XLEN-1:0] req_pc_q;
  logic                req_vld_q;
  logic                rsp_vld;
  fe_pkg::insn_t       rsp_insn;
  fe_pkg::exc_t        rsp_exc;

  // Hold buffer
  logic                buf_vld_q;
  logic [`FE_XLEN-1:0] buf_pc_q;
  fe_pkg::insn_t       buf_insn_q;
  fe_pkg::exc_t        buf_exc_q;

  ////////////////////
  // Request side

  // No new request while the if stage is held
  assign imem_req_o  = ~fetch_ctl_i.hold;
  assign imem_addr_o = pc_q;
  assign fetch_pc_o  = pc_q;

  // Load wins over hold
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni)                pc_q <= `FE_XLEN'(`FE_PC_INIT) & ADR_MASK;
    else if (fetch_ctl_i.load)  pc_q <= fetch_ctl_i.nxt_pc & ADR_MASK;
    else if (!fetch_ctl_i.hold) pc_q <= pc_q + `FE_XLEN'd4;
  end

  // Outstanding request, one cycle deep
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) req_vld_q <= 1'b0;
    else         req_vld_q <= imem_req_o;
  end

  always_ff @(posedge clk_i) begin
    if (imem_req_o) req_pc_q <= pc_q;
  end

  ////////////////////
  // Response side

  // Killed word is wrong path
  assign rsp_vld = req_vld_q & ~fetch_ctl_i.kill;

  always_comb begin
    rsp_insn.instr      = imem_instr_i;
    rsp_insn.bubble     = ~rsp_vld;
    rsp_exc.fetch_fault = rsp_vld & imem_err_i;
    rsp_exc.illegal     = 1'b0;
    rsp_exc.any         = rsp_vld & imem_err_i;
  end

  // Buffered word goes first
  assign if_insn_o = buf_vld_q ? buf_insn_q : rsp_insn;
  assign if_pc_o   = buf_vld_q ? buf_pc_q   : req_pc_q;
  assign if_exc_o  = buf_vld_q ? buf_exc_q  : rsp_exc;

  // Buffer lives only across a hold, a load drops it
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) buf_vld_q <= 1'b0;
    else         buf_vld_q <= fetch_ctl_i.hold & ~fetch_ctl_i.load;
  end

  always_ff @(posedge clk_i) begin
    if (fetch_ctl_i.hold) begin
      buf_insn_q <= if_insn_o;
      buf_pc_q   <= if_pc_o;
      buf_exc_q  <= if_exc_o;
    end
  end

endmodule

//--- design/fe_bht.sv
/* Branch history table
   Gshare table of 2-bit counters, read at fetch, trained by the branch unit */

`timescale 1ns/1ns
`include "fe_settings.svh"

module fe_bht (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`FE_XLEN-1:0]       fetch_pc_i,
  input  logic                      hold_i,
  input  fe_pkg::bp_update_t        bu_update_i,
  output logic [1:0]                bp_predict_o,
  output logic [`FE_HIST_BITS-1:0]  if_bp_history_o
);

  localparam int IDX_BITS = $clog2(`FE_BHT_ENTRIES);

  logic [1:0]               cnt_q [`FE_BHT_ENTRIES];
  logic [`FE_HIST_BITS-1:0] hist_q;
  logic [IDX_BITS-1:0]      rd_idx;
  logic [IDX_BITS-1:0]      wr_idx;
  logic [1:0]               wr_cnt;

  // Word address bits XOR global history
  function automatic logic [IDX_BITS-1:0] bht_index(
    input logic [`FE_XLEN-1:0]      pc,
    input logic [`FE_HIST_BITS-1:0] hist
  );
    return pc[IDX_BITS+1:2] ^ IDX_BITS'(hist);
  endfunction

  assign rd_idx = bht_index(fetch_pc_i, hist_q);
  assign wr_idx = bht_index(bu_update_i.pc, bu_update_i.history);

  ////////////////////
  // Training

  // Saturate toward the outcome
  always_comb begin
    wr_cnt = cnt_q[wr_idx];
    if (bu_update_i.taken && wr_cnt != 2'b11) begin
      wr_cnt = wr_cnt + 2'd1;
    end else if (!bu_update_i.taken && wr_cnt != 2'b00) begin
      wr_cnt = wr_cnt - 2'd1;
    end
  end

  // Start weakly not-taken
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `FE_BHT_ENTRIES; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (bu_update_i.valid) begin
      cnt_q[wr_idx] <= wr_cnt;
    end
  end

  // Newest outcome in bit 0
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni)                hist_q <= '0;
    else if (bu_update_i.valid) hist_q <= {hist_q[`FE_HIST_BITS-2:0], bu_update_i.taken};
  end

  ////////////////////
  // Lookup

  // Follows the request into the if stage
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      bp_predict_o    <= 2'b00;
      if_bp_history_o <= '0;
    end else if (!hold_i) begin
      bp_predict_o    <= cnt_q[rd_idx];
      if_bp_history_o <= hist_q;
    end
  end

endmodule

//--- design/fe_predecode.sv
/* Instruction pre-decode stage
   Register and CSR fields, JAL and branch prediction, CSR write stall,
   and the pipeline register toward decode */

`timescale 1ns/1ns
`include "fe_settings.svh"

module fe_predecode (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fe_stall_i,
  input  logic                      id_stall_i,
  input  logic                      pd_flush_i,
  input  logic                      later_exc_i,
  input  logic                      du_mode_i,
  input  logic [`FE_XLEN-1:0]       if_pc_i,
  input  fe_pkg::insn_t             if_insn_i,
  input  fe_pkg::exc_t              if_exc_i,
  input  logic [1:0]                bp_predict_i,
  input  logic [`FE_HIST_BITS-1:0]  if_bp_history_i,
  output logic                      local_stall_o,
  output logic                      redirect_o,
  output logic [`FE_XLEN-1:0]       redirect_pc_o,
  output fe_pkg::insn_t             pd_insn_o,
  output logic [`FE_XLEN-1:0]       pd_pc_o,
  output fe_pkg::exc_t              pd_exc_o,
  output fe_pkg::rsd_t              pd_rs1_o,
  output fe_pkg::rsd_t              pd_rs2_o,
  output logic [11:0]               pd_csr_reg_o,
  output logic [1:0]                pd_bp_predict_o,
  output logic [`FE_HIST_BITS-1:0]  pd_bp_history_o,
  output logic                      pd_stall_o,
  output logic                      pd_flush_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       csr_write;
  logic       local_stall;
  logic       kill_slot;
  logic       branch_taken;
  logic       taken_q;
  logic [1:0] branch_predicted;

  assign opcode = fe_pkg::decode_opcode(if_insn_i.instr);
  assign funct3 = fe_pkg::decode_funct3(if_insn_i.instr);

  // Fields straight from the if stage
  assign pd_rs1_o     = fe_pkg::decode_rs1(if_insn_i.instr);
  assign pd_rs2_o     = fe_pkg::decode_rs2(if_insn_i.instr);
  assign pd_csr_reg_o = fe_pkg::decode_csr(if_insn_i.instr);

  assign pd_flush_o = pd_flush_i;
  assign pd_stall_o = fe_stall_i;

  ////////////////////
  // CSR write stall

  // Set and clear forms write only with a nonzero source
  always_comb begin
    csr_write = 1'b0;
    if (opcode == fe_pkg::OPC_SYSTEM) begin
      case (funct3)
        fe_pkg::F3_CSRRW,
        fe_pkg::F3_CSRRWI: csr_write = 1'b1;
        fe_pkg::F3_CSRRS,
        fe_pkg::F3_CSRRC,
        fe_pkg::F3_CSRRSI,
        fe_pkg::F3_CSRRCI: csr_write = |fe_pkg::decode_rs1(if_insn_i.instr);
        default:           csr_write = 1'b0;
      endcase
    end
  end

  // One cycle only, then clears itself
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni)          local_stall <= 1'b0;
    else if (local_stall) local_stall <= 1'b0;
    else if (!id_stall_i) local_stall <= csr_write & ~if_insn_i.bubble;
  end

  assign local_stall_o = local_stall;

  ////////////////////
  // Jump and branch prediction

  always_comb begin
    branch_taken     = 1'b0;
    branch_predicted = 2'b00;
    redirect_pc_o    = if_pc_i + fe_pkg::decode_imm_sb(if_insn_i.instr);
    if (!du_mode_i && !if_insn_i.bubble) begin
      if (opcode == fe_pkg::OPC_JAL) begin
        // Always taken
        branch_taken     = 1'b1;
        branch_predicted = 2'b10;
        redirect_pc_o    = if_pc_i + fe_pkg::decode_imm_uj(if_insn_i.instr);
      end else if (opcode == fe_pkg::OPC_BRANCH) begin
        branch_taken     = bp_predict_i[1];
        branch_predicted = bp_predict_i;
      end
    end
  end

  // Taken counts only once the word moves on
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) taken_q <= 1'b0;
    else         taken_q <= branch_taken & ~fe_stall_i;
  end

  // First taken cycle
  assign redirect_o = branch_taken & ~fe_stall_i & ~taken_q;

  ////////////////////
  // Pipeline register

  // Slot emptied on flush, later exception or CSR stall
  assign kill_slot = pd_flush_i | later_exc_i | local_stall;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pd_insn_o.instr  <= fe_pkg::INSTR_NOP;
      pd_insn_o.bubble <= 1'b1;
      pd_exc_o         <= '0;
      pd_pc_o          <= `FE_XLEN'(`FE_PC_INIT);
      pd_bp_predict_o  <= 2'b00;
    end else begin
      if (kill_slot)        pd_insn_o.bubble <= 1'b1;
      else if (!fe_stall_i) pd_insn_o.bubble <= if_insn_i.bubble;
      if (kill_slot)        pd_exc_o <= '0;
      else if (!fe_stall_i) pd_exc_o <= if_exc_i;
      if (!fe_stall_i) begin
        pd_insn_o.instr <= if_insn_i.instr;
        pd_pc_o         <= if_pc_i;
        pd_bp_predict_o <= branch_predicted;
      end
    end
  end

  // History travels with the instruction
  always_ff @(posedge clk_i) begin
    if (!fe_stall_i) pd_bp_history_o <= if_bp_history_i;
  end

endmodule

//--- design/fe_top.sv
/* RV32 instruction front end
   Fetch, branch table, pre-decode and control wired together */

`timescale 1ns/1ns
`include "fe_settings.svh"

module fe_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Instruction memory
  output logic [`FE_XLEN-1:0]       imem_addr_o,
  output logic                      imem_req_o,
  input  fe_pkg::instr_t            imem_instr_i,
  input  logic                      imem_err_i,
  // Decode, branch unit, state unit
  input  logic                      id_stall_i,
  input  logic                      bu_flush_i,
  input  logic [`FE_XLEN-1:0]       bu_nxt_pc_i,
  input  fe_pkg::bp_update_t        bu_update_i,
  input  logic                      st_flush_i,
  input  logic [`FE_XLEN-1:0]       st_nxt_pc_i,
  input  logic                      later_exc_i,
  input  logic                      du_mode_i,
  // Toward decode
  output fe_pkg::insn_t             pd_insn_o,
  output logic [`FE_XLEN-1:0]       pd_pc_o,
  output fe_pkg::exc_t              pd_exc_o,
  output fe_pkg::rsd_t              pd_rs1_o,
  output fe_pkg::rsd_t              pd_rs2_o,
  output logic [11:0]               pd_csr_reg_o,
  output logic [1:0]                pd_bp_predict_o,
  output logic [`FE_HIST_BITS-1:0]  pd_bp_history_o,
  output logic                      pd_stall_o,
  output logic                      pd_flush_o
);

  fe_pkg::fetch_ctl_t       fetch_ctl;
  logic                     fe_stall;
  logic                     pd_flush;
  logic                     local_stall;
  logic                     pd_latch_nxt_pc;
  logic [`FE_XLEN-1:0]      pd_nxt_pc;
  logic [`FE_XLEN-1:0]      fetch_pc;
  logic [`FE_XLEN-1:0]      if_pc;
  fe_pkg::insn_t            if_insn;
  fe_pkg::exc_t             if_exc;
  logic [1:0]               bp_predict;
  logic [`FE_HIST_BITS-1:0] if_bp_history;

  fe_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .id_stall_i    (id_stall_i),
    .local_stall_i (local_stall),
    .st_flush_i    (st_flush_i),
    .st_nxt_pc_i   (st_nxt_pc_i),
    .bu_flush_i    (bu_flush_i),
    .bu_nxt_pc_i   (bu_nxt_pc_i),
    .redirect_i    (pd_latch_nxt_pc),
    .redirect_pc_i (pd_nxt_pc),
    .fetch_ctl_o   (fetch_ctl),
    .fe_stall_o    (fe_stall),
    .pd_flush_o    (pd_flush)
  );

  fe_fetch u_fetch (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_ctl_i  (fetch_ctl),
    .imem_instr_i (imem_instr_i),
    .imem_err_i   (imem_err_i),
    .imem_addr_o  (imem_addr_o),
    .imem_req_o   (imem_req_o),
    .fetch_pc_o   (fetch_pc),
    .if_pc_o      (if_pc),
    .if_insn_o    (if_insn),
    .if_exc_o     (if_exc)
  );

  fe_bht u_bht (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fetch_pc_i      (fetch_pc),
    .hold_i          (fe_stall),
    .bu_update_i     (bu_update_i),
    .bp_predict_o    (bp_predict),
    .if_bp_history_o (if_bp_history)
  );

  fe_predecode u_predecode (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fe_stall_i      (fe_stall),
    .id_stall_i      (id_stall_i),
    .pd_flush_i      (pd_flush),
    .later_exc_i     (later_exc_i),
    .du_mode_i       (du_mode_i),
    .if_pc_i         (if_pc),
    .if_insn_i       (if_insn),
    .if_exc_i        (if_exc),
    .bp_predict_i    (bp_predict),
    .if_bp_history_i (if_bp_history),
    .local_stall_o   (local_stall),
    .redirect_o      (pd_latch_nxt_pc),
    .redirect_pc_o   (pd_nxt_pc),
    .pd_insn_o       (pd_insn_o),
    .pd_pc_o         (pd_pc_o),
    .pd_exc_o        (pd_exc_o),
    .pd_rs1_o        (pd_rs1_o),
    .pd_rs2_o        (pd_rs2_o),
    .pd_csr_reg_o    (pd_csr_reg_o),
    .pd_bp_predict_o (pd_bp_predict_o),
    .pd_bp_history_o (pd_bp_history_o),
    .pd_stall_o      (pd_stall_o),
    .pd_flush_o      (pd_flush_o)
  );

endmodule

//--- verif/fe_tests.svh
/* Front end directed tests
   One task per behavior, expected values from memory contents and ISA encoding */

function automatic logic [31:0] enc_jal(input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
endfunction

function automatic logic [31:0] enc_branch(input logic [12:0] off);
  return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_csr(input logic [4:0] rs1, input logic [2:0] f3);
  return {12'h300, rs1, f3, 5'd3, 7'b1110011};
endfunction

task automatic test_reset();
  cur_test = "reset";
  check_eq("bubble", 1, pd_insn_o.bubble);
  check_eq("pc", `FE_PC_INIT, pd_pc_o);
  check_eq("exc", 0, pd_exc_o);
  check_eq("stall", 0, pd_stall_o);
  check_eq("predict", 0, pd_bp_predict_o);
  check_eq("req", 1, imem_req_o);
endtask

task automatic test_sequential();
  logic [31:0] w;
  logic [4:0]  prev_rs1;
  logic [4:0]  prev_rs2;
  logic [11:0] prev_csr;
  int          n;
  int          ticks;
  cur_test = "sequential";
  restart_at(32'h400);
  n     = 0;
  ticks = 0;
  while (n < 8 && ticks < 30) begin
    // Register fields come from the if stage, one cycle ahead of pd
    @(negedge clk_i);
    prev_rs1 = pd_rs1_o;
    prev_rs2 = pd_rs2_o;
    prev_csr = pd_csr_reg_o;
    step_cycle();
    ticks++;
    if (!pd_insn_o.bubble) begin
      w = mem[widx(32'h400 + 4 * n)];
      check_eq("pc", 32'h400 + 4 * n, pd_pc_o);
      check_eq("instr", w, pd_insn_o.instr);
      check_eq("rs1", w[19:15], prev_rs1);
      check_eq("rs2", w[24:20], prev_rs2);
      check_eq("csr", w[31:20], prev_csr);
      n++;
    end
  end
  check_eq("count", 8, n);
endtask

task automatic test_jal();
  logic [31:0] pc;
  cur_test = "jal";
  mem[widx(32'h608)] = enc_jal(21'h40);
  restart_at(32'h600);
  next_valid(pc);
  check_eq("pc0", 32'h600, pc);
  next_valid(pc);
  check_eq("pc1", 32'h604, pc);
  next_valid(pc);
  check_eq("jal pc", 32'h608, pc);
  check_eq("jal predict", 2'b10, pd_bp_predict_o);
  // Wrong-path word behind the JAL is killed
  next_valid(pc);
  check_eq("target", 32'h648, pc);

  cur_test = "jal debug";
  du_mode_i = 1'b1;
  restart_at(32'h600);
  next_valid(pc);
  next_valid(pc);
  next_valid(pc);
  check_eq("jal pc", 32'h608, pc);
  check_eq("jal predict", 2'b00, pd_bp_predict_o);
  next_valid(pc);
  check_eq("fall through", 32'h60c, pc);
  du_mode_i = 1'b0;
endtask

task automatic test_branch();
  logic [31:0] pc;
  logic [1:0]  hist;
  cur_test = "branch untrained";
  mem[widx(32'h808)] = enc_branch(13'h20);
  restart_at(32'h800);
  next_valid(pc);
  next_valid(pc);
  next_valid(pc);
  check_eq("br pc", 32'h808, pc);
  check_eq("br predict", 2'b01, pd_bp_predict_o);
  next_valid(pc);
  check_eq("fall through", 32'h80c, pc);

  cur_test = "branch trained";
  // History after two taken outcomes, newest in bit 0
  hist = 2'b00;
  hist = {hist[0], 1'b1};
  hist = {hist[0], 1'b1};
  // Same history in the update hits the counter read at fetch
  repeat (2) begin
    bu_update_i.valid   = 1'b1;
    bu_update_i.pc      = 32'h808;
    bu_update_i.taken   = 1'b1;
    bu_update_i.history = hist;
    step_cycle();
    bu_update_i = '0;
  end
  restart_at(32'h800);
  next_valid(pc);
  next_valid(pc);
  next_valid(pc);
  check_eq("br pc", 32'h808, pc);
  check_eq("br predict", 2'b11, pd_bp_predict_o);
  check_eq("br history", hist, pd_bp_history_o);
  next_valid(pc);
  check_eq("target", 32'h828, pc);
endtask

// CSR word sits at base+4, stream must stay gap free
task automatic csr_run(input logic [31:0] base, input logic [31:0] word,
                       input int exp_stalls);
  logic [31:0] pcs [$];
  int          stalls;
  mem[widx(base + 4)] = word;
  restart_at(base);
  stalls = 0;
  repeat (12) begin
    step_cycle();
    if (pd_stall_o) stalls++;
    if (!pd_insn_o.bubble) pcs.push_back(pd_pc_o);
  end
  check_eq("stall cycles", exp_stalls, stalls);
  check_eq("enough words", 1, pcs.size() >= 6);
  for (int k = 0; k < 6 && k < pcs.size(); k++) begin
    check_eq("pc", base + 4 * k, pcs[k]);
  end
endtask

task automatic test_csr();
  cur_test = "csrrw";
  csr_run(32'ha00, enc_csr(5'd5, 3'b001), 1);
  cur_test = "csrrs x0";
  csr_run(32'hc00, enc_csr(5'd0, 3'b010), 0);
endtask

task automatic test_flush();
  logic [31:0] pc;
  cur_test = "flush priority";
  st_flush_i  = 1'b1;
  st_nxt_pc_i = 32'he00;
  bu_flush_i  = 1'b1;
  bu_nxt_pc_i = 32'hf00;
  #1;
  check_eq("pd flush", 1, pd_flush_o);
  step_cycle();
  st_flush_i = 1'b0;
  bu_flush_i = 1'b0;
  next_valid(pc);
  check_eq("target", 32'he00, pc);

  cur_test = "later exception";
  later_exc_i = 1'b1;
  repeat (6) begin
    step_cycle();
    check_eq("bubble", 1, pd_insn_o.bubble);
  end
  later_exc_i = 1'b0;

  cur_test = "fetch fault";
  err_map[widx(32'he48)] = 1'b1;
  restart_at(32'he40);
  next_valid(pc);
  check_eq("exc e40", 3'b000, pd_exc_o);
  next_valid(pc);
  check_eq("exc e44", 3'b000, pd_exc_o);
  next_valid(pc);
  check_eq("fault pc", 32'he48, pc);
  // Fault and any bits set, illegal clear
  check_eq("exc e48", 3'b101, pd_exc_o);
  err_map[widx(32'he48)] = 1'b0;
endtask

//--- verif/fe_tb.sv
/* Front end testbench
   Clock, reset, instruction memory model, checking and run control */

`timescale 1ns/1ns
`include "fe_settings.svh"

module fe_tb;

  // About 85 cycles of tests plus margin
  localparam int MAX_CYCLES = 200;

  logic                     clk_i;
  logic                     rst_ni;
  logic [`FE_XLEN-1:0]      imem_addr_o;
  logic                     imem_req_o;
  fe_pkg::instr_t           imem_instr_i;
  logic                     imem_err_i;
  logic                     id_stall_i;
  logic                     bu_flush_i;
  logic [`FE_XLEN-1:0]      bu_nxt_pc_i;
  fe_pkg::bp_update_t       bu_update_i;
  logic                     st_flush_i;
  logic [`FE_XLEN-1:0]      st_nxt_pc_i;
  logic                     later_exc_i;
  logic                     du_mode_i;
  fe_pkg::insn_t            pd_insn_o;
  logic [`FE_XLEN-1:0]      pd_pc_o;
  fe_pkg::exc_t             pd_exc_o;
  fe_pkg::rsd_t             pd_rs1_o;
  fe_pkg::rsd_t             pd_rs2_o;
  logic [11:0]              pd_csr_reg_o;
  logic [1:0]               pd_bp_predict_o;
  logic [`FE_HIST_BITS-1:0] pd_bp_history_o;
  logic                     pd_stall_o;
  logic                     pd_flush_o;

  // 4 KB of word memory with a fault flag per word
  logic [31:0]         mem [1024];
  logic                err_map [1024];
  logic [`FE_XLEN-1:0] lat_addr;

  string cur_test;
  int    cycles;

  fe_top dut (.*);

  always #20 clk_i = ~clk_i;

  ////////////////////
  // Memory model

  // Answers the address of the previous cycle
  always @(posedge clk_i) begin
    lat_addr <= imem_addr_o;
    #5;
    imem_instr_i = mem[lat_addr[11:2]];
    imem_err_i   = err_map[lat_addr[11:2]];
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // Helpers

  function automatic int widx(input logic [31:0] a);
    return int'(a[11:2]);
  endfunction

  // R-type add with random registers
  function automatic logic [31:0] alu_word();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    rd  = 5'($urandom);
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  task automatic step_cycle();
    @(posedge clk_i);
    #5;
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
      $display(">>> FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  // Steps until decode sees a real instruction
  task automatic next_valid(output logic [31:0] pc);
    int waited;
    waited = 0;
    step_cycle();
    while (pd_insn_o.bubble && waited < 20) begin
      step_cycle();
      waited++;
    end
    if (pd_insn_o.bubble) begin
      $display("%s: no instruction reached decode within 20 cycles", cur_test);
      $display(">>> FAIL");
      $fatal(1, "no instruction");
    end
    pc = pd_pc_o;
  endtask

  // State flush to a new fetch address
  task automatic restart_at(input logic [31:0] pc);
    st_flush_i  = 1'b1;
    st_nxt_pc_i = pc;
    step_cycle();
    st_flush_i  = 1'b0;
  endtask

  `include "fe_tests.svh"

  ////////////////////
  // Main

  initial begin
    void'($urandom(9));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    imem_instr_i = fe_pkg::INSTR_NOP;
    imem_err_i   = 1'b0;
    id_stall_i   = 1'b0;
    bu_flush_i   = 1'b0;
    bu_nxt_pc_i  = '0;
    bu_update_i  = '0;
    st_flush_i   = 1'b0;
    st_nxt_pc_i  = '0;
    later_exc_i  = 1'b0;
    du_mode_i    = 1'b0;
    cycles       = 0;
    for (int i = 0; i < 1024; i++) begin
      mem[i]     = alu_word();
      err_map[i] = 1'b0;
    end
    repeat (4) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;

    test_reset();
    test_sequential();
    test_jal();
    test_branch();
    test_csr();
    test_flush();

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- project.f
+incdir+design
+incdir+verif
design/fe_pkg.sv
design/fe_ctrl.sv
design/fe_fetch.sv
design/fe_bht.sv
design/fe_predecode.sv
design/fe_top.sv
verif/fe_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wall -f project.f --top-module fe_tb \
  -Mdir obj_dir -o fe_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1
